// ==== hw/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

  localparam int arch_regs = 32;
  localparam int phys_regs = 64;
  localparam int free_depth = phys_regs - arch_regs;
  localparam int issue_width = 2;

  typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;
  typedef logic [$clog2(phys_regs)-1:0] phys_tag_t;

  // slot index with one wrap bit on top.
  typedef logic [$clog2(free_depth):0] fl_ptr_t;

  // has_dest is only set for a nonzero dest.
  typedef struct packed {
    logic      has_dest;
    arch_idx_t dest;
    arch_idx_t src1;
    arch_idx_t src2;
  } decoded_inst_t;

  typedef struct packed {
    logic      has_dest;
    arch_idx_t dest;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
  } retire_slot_t;

  typedef struct packed {
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t old_tag;
  } lookup_t;

  typedef struct packed {
    logic      en;
    arch_idx_t dest;
    phys_tag_t tag;
  } map_write_t;

  typedef struct packed {
    logic      has_dest;
    phys_tag_t new_tag;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t old_tag;
  } renamed_inst_t;

endpackage

`default_nettype wire

// ==== hw/free_list.sv ====
`timescale 1ns/1ns
`default_nettype none

module free_list (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  logic                                                     rollback,
  input  logic                                                     accept,
  input  rename_pkg::decoded_inst_t [rename_pkg::issue_width-1:0]  inst,
  input  logic                      [rename_pkg::issue_width-1:0]  retire_en,
  input  rename_pkg::retire_slot_t  [rename_pkg::issue_width-1:0]  retire,
  output rename_pkg::phys_tag_t     [rename_pkg::issue_width-1:0]  new_tag,
  output logic                                                     ready
);

  import rename_pkg::*;

  localparam int slot_bits = $clog2(free_depth);

  phys_tag_t tag_table [free_depth];

  fl_ptr_t alloc_ptr;
  fl_ptr_t alloc_ptr_1;
  fl_ptr_t ins_ptr;
  fl_ptr_t ins_ptr_1;
  fl_ptr_t ins_next;
  fl_ptr_t free_count;
  fl_ptr_t need;
  logic    release_0;
  logic    release_1;

  // tags wanted by this pair.
  assign need = fl_ptr_t'(inst[0].has_dest) + fl_ptr_t'(inst[1].has_dest);

  // wrap bits keep a full list apart from an empty one.
  assign free_count = ins_ptr - alloc_ptr;
  assign ready = free_count >= need;

  // slot 1 takes the next entry only when slot 0 also allocates.
  assign alloc_ptr_1 = alloc_ptr + fl_ptr_t'(inst[0].has_dest);

  assign new_tag[0] = tag_table[alloc_ptr[slot_bits-1:0]];
  assign new_tag[1] = tag_table[alloc_ptr_1[slot_bits-1:0]];

  // slot 1 retires only together with slot 0.
  assign release_0 = retire_en[0] && retire[0].has_dest;
  assign release_1 = (&retire_en) && retire[1].has_dest;

  assign ins_ptr_1 = ins_ptr + fl_ptr_t'(release_0);
  assign ins_next = ins_ptr_1 + fl_ptr_t'(release_1);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < free_depth; i++) begin
        tag_table[i] <= phys_tag_t'(arch_regs + i);
      end
    end else begin
      if (release_0) begin
        tag_table[ins_ptr[slot_bits-1:0]] <= retire[0].old_tag;
      end
      if (release_1) begin
        tag_table[ins_ptr_1[slot_bits-1:0]] <= retire[1].old_tag;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alloc_ptr <= '0;
      ins_ptr <= fl_ptr_t'(free_depth);
    end else begin
      ins_ptr <= ins_next;
      if (rollback) begin
        // every in-flight tag comes back, so the list is full again.
        alloc_ptr <= {~ins_next[slot_bits], ins_next[slot_bits-1:0]};
      end else if (accept) begin
        alloc_ptr <= alloc_ptr + need;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/map_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module map_table (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  logic                                                     rollback,
  input  rename_pkg::decoded_inst_t [rename_pkg::issue_width-1:0]  inst,
  input  rename_pkg::map_write_t    [rename_pkg::issue_width-1:0]  map_wr,
  input  logic                      [rename_pkg::issue_width-1:0]  retire_en,
  input  rename_pkg::retire_slot_t  [rename_pkg::issue_width-1:0]  retire,
  output rename_pkg::lookup_t       [rename_pkg::issue_width-1:0]  lookup
);

  import rename_pkg::*;

  phys_tag_t spec_map [arch_regs];
  phys_tag_t arch_map [arch_regs];
  phys_tag_t arch_next [arch_regs];

  // both slots read the speculative map as it stands.
  always_comb begin
    for (int i = 0; i < issue_width; i++) begin
      lookup[i].src1_tag = spec_map[inst[i].src1];
      lookup[i].src2_tag = spec_map[inst[i].src2];
      lookup[i].old_tag = spec_map[inst[i].dest];
    end
  end

  // committed map including this cycle's retirements.
  always_comb begin
    arch_next = arch_map;
    if (retire_en[0] && retire[0].has_dest) begin
      arch_next[retire[0].dest] = retire[0].new_tag;
    end
    if ((&retire_en) && retire[1].has_dest) begin
      arch_next[retire[1].dest] = retire[1].new_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arch_regs; i++) begin
        arch_map[i] <= phys_tag_t'(i);
      end
    end else begin
      arch_map <= arch_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arch_regs; i++) begin
        spec_map[i] <= phys_tag_t'(i);
      end
    end else if (rollback) begin
      spec_map <= arch_next;
    end else begin
      // later slot overrides, so slot 1 wins a shared dest.
      for (int i = 0; i < issue_width; i++) begin
        if (map_wr[i].en) begin
          spec_map[map_wr[i].dest] <= map_wr[i].tag;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/rename_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_merge (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  logic                                                     dispatch,
  input  logic                                                     rollback,
  input  logic                                                     ready,
  input  rename_pkg::decoded_inst_t [rename_pkg::issue_width-1:0]  inst,
  input  rename_pkg::phys_tag_t     [rename_pkg::issue_width-1:0]  new_tag,
  input  rename_pkg::lookup_t       [rename_pkg::issue_width-1:0]  lookup,
  output logic                                                     accept,
  output rename_pkg::map_write_t    [rename_pkg::issue_width-1:0]  map_wr,
  output logic                                                     out_valid,
  output rename_pkg::renamed_inst_t [rename_pkg::issue_width-1:0]  out
);

  import rename_pkg::*;

  renamed_inst_t [issue_width-1:0] renamed;

  logic src1_hit;
  logic src2_hit;
  logic dest_hit;

  // rollback wins over dispatch.
  assign accept = dispatch && ready && !rollback;

  // slot 1 against slot 0's destination.
  assign src1_hit = inst[0].has_dest && (inst[1].src1 == inst[0].dest);
  assign src2_hit = inst[0].has_dest && (inst[1].src2 == inst[0].dest);
  assign dest_hit = inst[0].has_dest && inst[1].has_dest && (inst[1].dest == inst[0].dest);

  always_comb begin
    for (int i = 0; i < issue_width; i++) begin
      map_wr[i].en = accept && inst[i].has_dest;
      map_wr[i].dest = inst[i].dest;
      map_wr[i].tag = new_tag[i];
    end
  end

  always_comb begin
    renamed[0].has_dest = inst[0].has_dest;
    renamed[0].new_tag = inst[0].has_dest ? new_tag[0] : '0;
    renamed[0].src1_tag = lookup[0].src1_tag;
    renamed[0].src2_tag = lookup[0].src2_tag;
    renamed[0].old_tag = inst[0].has_dest ? lookup[0].old_tag : '0;

    renamed[1].has_dest = inst[1].has_dest;
    renamed[1].new_tag = inst[1].has_dest ? new_tag[1] : '0;
    renamed[1].src1_tag = src1_hit ? new_tag[0] : lookup[1].src1_tag;
    renamed[1].src2_tag = src2_hit ? new_tag[0] : lookup[1].src2_tag;
    if (dest_hit) begin
      renamed[1].old_tag = new_tag[0];
    end else begin
      renamed[1].old_tag = inst[1].has_dest ? lookup[1].old_tag : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accept;
    end
  end

  // bundle holds until the next accepted pair.
  always_ff @(posedge clock) begin
    if (accept) begin
      out <= renamed;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rename_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_unit (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  logic                                                     dispatch,
  input  rename_pkg::decoded_inst_t [rename_pkg::issue_width-1:0]  inst,
  input  logic                      [rename_pkg::issue_width-1:0]  retire_en,
  input  rename_pkg::retire_slot_t  [rename_pkg::issue_width-1:0]  retire,
  input  logic                                                     rollback,
  output logic                                                     ready,
  output logic                                                     out_valid,
  output rename_pkg::renamed_inst_t [rename_pkg::issue_width-1:0]  out
);

  import rename_pkg::*;

  logic                          accept;
  phys_tag_t  [issue_width-1:0]  new_tag;
  lookup_t    [issue_width-1:0]  lookup;
  map_write_t [issue_width-1:0]  map_wr;

  free_list u_free_list (
    .clock     (clock),
    .reset     (reset),
    .rollback  (rollback),
    .accept    (accept),
    .inst      (inst),
    .retire_en (retire_en),
    .retire    (retire),
    .new_tag   (new_tag),
    .ready     (ready)
  );

  map_table u_map_table (
    .clock     (clock),
    .reset     (reset),
    .rollback  (rollback),
    .inst      (inst),
    .map_wr    (map_wr),
    .retire_en (retire_en),
    .retire    (retire),
    .lookup    (lookup)
  );

  rename_merge u_rename_merge (
    .clock     (clock),
    .reset     (reset),
    .dispatch  (dispatch),
    .rollback  (rollback),
    .ready     (ready),
    .inst      (inst),
    .new_tag   (new_tag),
    .lookup    (lookup),
    .accept    (accept),
    .map_wr    (map_wr),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

`default_nettype wire

// ==== testbench/rename_unit_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_unit_asserts (
  input logic clock,
  input logic reset,
  input logic dispatch,
  input logic rollback,
  input logic ready,
  input logic out_valid
);

  logic accepted;

  assign accepted = dispatch && ready && !rollback;

  reset_clears_valid: assert property (@(posedge clock) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  valid_needs_accept: assert property (@(posedge clock) disable iff (reset)
    out_valid |-> $past(accepted))
    else $error("out_valid without an accepted dispatch one cycle earlier");

  accept_gives_valid: assert property (@(posedge clock) disable iff (reset)
    accepted |=> out_valid)
    else $error("accepted dispatch gave no out_valid");

  // the whole list is free again after a rollback.
  ready_after_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback |=> ready)
    else $error("ready low in the cycle after rollback");

endmodule

bind rename_unit rename_unit_asserts u_rename_unit_asserts (
  .clock     (clock),
  .reset     (reset),
  .dispatch  (dispatch),
  .rollback  (rollback),
  .ready     (ready),
  .out_valid (out_valid)
);

`default_nettype wire

// ==== testbench/tb_rename_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rename_unit;

  import rename_pkg::*;

  localparam int max_cycles = 2000;
  localparam int slot_bits = $clog2(free_depth);
  localparam decoded_inst_t nop = '0;

  logic                            clock;
  logic                            reset;
  logic                            dispatch;
  logic                            rollback;
  logic                            ready;
  logic                            out_valid;
  logic [issue_width-1:0]          retire_en;
  decoded_inst_t [issue_width-1:0] inst;
  retire_slot_t [issue_width-1:0]  retire;
  renamed_inst_t [issue_width-1:0] out;

  // reference model of the rename state.
  phys_tag_t m_spec [arch_regs];
  phys_tag_t m_arch [arch_regs];
  phys_tag_t m_free [free_depth];
  fl_ptr_t m_alloc;
  fl_ptr_t m_ins;
  retire_slot_t in_flight [$];
  logic exp_valid;
  renamed_inst_t [issue_width-1:0] exp_out;

  int cycles = 0;
  int errors = 0;
  int errors_at_start;
  int tests_run = 0;
  int tests_failed = 0;
  string test_name;

  rename_unit UUT (
    .clock     (clock),
    .reset     (reset),
    .dispatch  (dispatch),
    .inst      (inst),
    .retire_en (retire_en),
    .retire    (retire),
    .rollback  (rollback),
    .ready     (ready),
    .out_valid (out_valid),
    .out       (out)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
    end
  endtask

  function automatic logic model_ready(input decoded_inst_t i0, input decoded_inst_t i1);
    fl_ptr_t count;
    count = m_ins - m_alloc;
    return int'(count) >= int'(i0.has_dest) + int'(i1.has_dest);
  endfunction

  // small register range so pairs collide often.
  function automatic decoded_inst_t rand_inst(input logic force_dest);
    decoded_inst_t i;
    i.has_dest = force_dest || ($urandom_range(0, 3) != 0);
    i.dest = i.has_dest ? arch_idx_t'($urandom_range(1, 15)) : '0;
    i.src1 = arch_idx_t'($urandom_range(0, 15));
    i.src2 = arch_idx_t'($urandom_range(0, 15));
    return i;
  endfunction

  // renames in program order, so slot 1 sees slot 0's mapping.
  task automatic rename_pair(input decoded_inst_t i0, input decoded_inst_t i1);
    decoded_inst_t [issue_width-1:0] pair;
    retire_slot_t entry;
    pair = {i1, i0};
    for (int s = 0; s < issue_width; s++) begin
      exp_out[s] = '0;
      entry = '0;
      exp_out[s].has_dest = pair[s].has_dest;
      exp_out[s].src1_tag = m_spec[pair[s].src1];
      exp_out[s].src2_tag = m_spec[pair[s].src2];
      if (pair[s].has_dest) begin
        exp_out[s].new_tag = m_free[m_alloc[slot_bits-1:0]];
        exp_out[s].old_tag = m_spec[pair[s].dest];
        m_spec[pair[s].dest] = exp_out[s].new_tag;
        m_alloc = m_alloc + fl_ptr_t'(1);
        entry = '{1'b1, pair[s].dest, exp_out[s].new_tag, exp_out[s].old_tag};
      end
      in_flight.push_back(entry);
    end
  endtask

  task automatic check_output();
    check_value("out_valid", 32'(exp_valid), 32'(out_valid));
    if (exp_valid && out_valid) begin
      for (int s = 0; s < issue_width; s++) begin
        check_value($sformatf("slot %0d bundle", s), 32'(exp_out[s]), 32'(out[s]));
      end
    end
  endtask

  task automatic step(input logic d, input decoded_inst_t i0, input decoded_inst_t i1,
                      input int n_retire, input logic rb);
    retire_slot_t [issue_width-1:0] ret;
    logic [issue_width-1:0] ret_en;
    logic rdy;
    ret = '0;
    ret_en = '0;
    // oldest in-flight instructions retire first.
    for (int k = 0; k < n_retire && in_flight.size() > 0; k++) begin
      ret[k] = in_flight.pop_front();
      ret_en[k] = 1'b1;
    end
    @(posedge clock);
    dispatch <= d;
    inst <= {i1, i0};
    retire_en <= ret_en;
    retire <= ret;
    rollback <= rb;
    @(negedge clock);
    check_output();
    rdy = model_ready(i0, i1);
    check_value("ready", 32'(rdy), 32'(ready));
    exp_valid = d && rdy && !rb;
    if (exp_valid) begin
      rename_pair(i0, i1);
    end
    for (int s = 0; s < issue_width; s++) begin
      if (ret_en[s] && ret[s].has_dest) begin
        m_free[m_ins[slot_bits-1:0]] = ret[s].old_tag;
        m_ins = m_ins + fl_ptr_t'(1);
        m_arch[ret[s].dest] = ret[s].new_tag;
      end
    end
    if (rb) begin
      m_spec = m_arch;
      m_alloc = m_ins ^ fl_ptr_t'(free_depth);
      in_flight.delete();
    end
  endtask

  task automatic idle();
    step(1'b0, nop, nop, 0, 1'b0);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
    end else begin
      $display("test %s passed", test_name);
    end
  endtask

  task automatic test_first_pair();
    decoded_inst_t a;
    decoded_inst_t b;
    start_test("first_pair");
    a = '{1'b1, 5'd3, 5'd1, 5'd2};
    b = '{1'b1, 5'd4, 5'd5, 5'd6};
    step(1'b1, a, b, 0, 1'b0);
    idle();
    // first tags sit just above the architectural range.
    check_value("slot 0 new_tag", 32, 32'(out[0].new_tag));
    check_value("slot 1 new_tag", 33, 32'(out[1].new_tag));
    check_value("slot 1 src2_tag", 6, 32'(out[1].src2_tag));
    check_value("slot 1 old_tag", 4, 32'(out[1].old_tag));
    finish_test();
  endtask

  task automatic test_in_pair();
    decoded_inst_t a;
    decoded_inst_t b;
    start_test("in_pair");
    a = '{1'b1, 5'd7, 5'd1, 5'd2};
    b = '{1'b1, 5'd8, 5'd7, 5'd7};
    step(1'b1, a, b, 0, 1'b0);
    idle();
    // tags 32 and 33 went to the first pair.
    check_value("bypassed src1", 34, 32'(out[1].src1_tag));
    check_value("bypassed src2", 34, 32'(out[1].src2_tag));
    a = '{1'b1, 5'd9, 5'd3, 5'd9};
    b = '{1'b1, 5'd9, 5'd9, 5'd4};
    step(1'b1, a, b, 0, 1'b0);
    idle();
    check_value("shared dest old_tag", 36, 32'(out[1].old_tag));
    a = '{1'b1, 5'd10, 5'd9, 5'd0};
    step(1'b1, a, nop, 0, 1'b0);
    idle();
    check_value("later reader src1", 37, 32'(out[0].src1_tag));
    finish_test();
  endtask

  task automatic test_no_dest();
    decoded_inst_t a;
    decoded_inst_t b;
    start_test("no_dest");
    a = '{1'b0, 5'd0, 5'd2, 5'd3};
    b = '{1'b1, 5'd11, 5'd1, 5'd2};
    step(1'b1, a, b, 0, 1'b0);
    idle();
    check_value("slot 0 has_dest", 0, 32'(out[0].has_dest));
    check_value("slot 1 new_tag", 39, 32'(out[1].new_tag));
    step(1'b1, b, a, 0, 1'b0);
    idle();
    // nothing has retired yet, so tags run in order.
    check_value("next tag", 40, 32'(out[0].new_tag));
    finish_test();
  endtask

  task automatic test_exhaust();
    decoded_inst_t a;
    decoded_inst_t b;
    start_test("exhaust");
    step(1'b0, nop, nop, 0, 1'b1);
    for (int k = 0; k < 16; k++) begin
      step(1'b1, rand_inst(1'b1), rand_inst(1'b1), 0, 1'b0);
    end
    a = rand_inst(1'b1);
    b = rand_inst(1'b1);
    step(1'b1, a, b, 0, 1'b0);
    check_value("ready with empty list", 0, 32'(ready));
    // held pair retries while the oldest pair retires.
    step(1'b1, a, b, 2, 1'b0);
    step(1'b1, a, b, 0, 1'b0);
    idle();
    finish_test();
  endtask

  task automatic test_rollback();
    decoded_inst_t a;
    start_test("rollback");
    for (int k = 0; k < 8; k++) begin
      step(1'b1, rand_inst(1'b0), rand_inst(1'b0), (k < 4) ? 2 : 0, 1'b0);
    end
    step(1'b0, nop, nop, 1, 1'b1);
    a = rand_inst(1'b1);
    step(1'b1, a, rand_inst(1'b0), 0, 1'b0);
    idle();
    check_value("src1 after rollback", 32'(m_arch[a.src1]), 32'(out[0].src1_tag));
    check_value("src2 after rollback", 32'(m_arch[a.src2]), 32'(out[0].src2_tag));
    finish_test();
  endtask

  task automatic test_random_mix();
    start_test("random_mix");
    for (int c = 0; c < 300; c++) begin
      step($urandom_range(0, 3) != 0, rand_inst(1'b0), rand_inst(1'b0),
           int'($urandom_range(0, 2)), $urandom_range(0, 39) == 0);
    end
    idle();
    finish_test();
  endtask

  initial begin
    void'($urandom(37924));
    reset = 1'b1;
    dispatch = 1'b0;
    rollback = 1'b0;
    inst = '0;
    retire_en = '0;
    retire = '0;
    for (int i = 0; i < arch_regs; i++) begin
      m_spec[i] = phys_tag_t'(i);
      m_arch[i] = phys_tag_t'(i);
    end
    for (int i = 0; i < free_depth; i++) begin
      m_free[i] = phys_tag_t'(arch_regs + i);
    end
    m_alloc = '0;
    m_ins = fl_ptr_t'(free_depth);
    exp_valid = 1'b0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    test_first_pair();
    test_in_pair();
    test_no_dest();
    test_exhaust();
    test_rollback();
    test_random_mix();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/rename_pkg.sv
hw/free_list.sv
hw/map_table.sv
hw/rename_merge.sv
hw/rename_unit.sv
testbench/rename_unit_asserts.sv
testbench/tb_rename_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_rename_unit
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Simulation finished: PASS
BUILD_FLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall

SOURCES := $(wildcard hw/*.sv testbench/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
